// File: testbench/cutter_patterns.hex
// Columns: type a b c, all hex
// type 1 config: cut_en cut_words cut_bytes
// type 2 packet: in_len exp_len exp_beats
// type 3 ready gaps: on 0 0, type 0 ends the list
1 0 3 5   // cutting off
2 1 1 1
2 8 8 1
2 d d 2
2 28 28 5
2 3d 3d 8
1 1 3 5   // limit 21 bytes
2 15 15 3
2 10 10 2
2 16 15 3
2 40 15 3
2 5 5 1
1 1 2 0   // zero bytes means full beat, limit 16
2 30 10 2
2 10 10 2
2 11 10 2
1 1 1 3   // limit 3
2 20 3 1
2 3 3 1
1 1 4 c   // oversized byte count, limit 32
2 64 20 4
1 1 0 4   // zero words never cuts
2 30 30 6
3 1 0 0   // random output back-pressure
1 0 3 5
2 3d 3d 8
2 d d 2
1 1 3 5
2 40 15 3
2 15 15 3
2 16 15 3
1 1 2 0
2 11 10 2
2 30 10 2
3 0 0 0
0 0 0 0

// File: filelist.f
rtl/cutter_pkg.sv
rtl/cutter_regs.sv
rtl/cut_control.sv
rtl/cut_output_stage.sv
rtl/packet_cutter_top.sv
testbench/tb_packet_cutter.sv

// File: Bender.yml
package:
  name: packet_cutter

sources:
  - files:
      - rtl/cutter_pkg.sv
      - rtl/cutter_regs.sv
      - rtl/cut_control.sv
      - rtl/cut_output_stage.sv
      - rtl/packet_cutter_top.sv
  - target: test
    files:
      - testbench/tb_packet_cutter.sv

// File: testbench/tb_packet_cutter.sv
//##########################################################
// Packet cutter testbench
// Register and stream checks driven by the pattern file
//##########################################################

`timescale 1ns/1ps

module tb_packet_cutter;
  import cutter_pkg::*;

  localparam int DATA_WIDTH  = 64;
  localparam int TUSER_WIDTH = 128;
  localparam int BYTES       = DATA_WIDTH / 8;
  localparam int PAT_DEPTH   = 256;
  localparam int TIMEOUT     = 200;

  logic                      axi_aclk;
  logic                      reset;
  logic                      reg_write;
  logic                      reg_read;
  logic [REG_ADDR_WIDTH-1:0] reg_addr;
  logic [REG_WIDTH-1:0]      reg_wdata;
  logic [REG_WIDTH-1:0]      reg_rdata;
  logic                      reg_rvalid;
  logic [DATA_WIDTH-1:0]     s_tdata;
  logic [BYTES-1:0]          s_tstrb;
  logic [TUSER_WIDTH-1:0]    s_tuser;
  logic                      s_tvalid;
  logic                      s_tready;
  logic                      s_tlast;
  logic [DATA_WIDTH-1:0]     m_tdata;
  logic [BYTES-1:0]          m_tstrb;
  logic [TUSER_WIDTH-1:0]    m_tuser;
  logic                      m_tvalid;
  logic                      m_tready;
  logic                      m_tlast;

  logic [31:0]            pat_mem [0:PAT_DEPTH-1];
  // Kept beats still to come out of the DUT
  logic [DATA_WIDTH-1:0]  exp_data [$];
  logic [BYTES-1:0]       exp_strb [$];
  logic [TUSER_WIDTH-1:0] exp_user [$];
  logic                   exp_last [$];

  int          errors;
  int          tests;
  int          rx_beats;
  logic        gaps_on;
  logic [31:0] data_state;
  logic [31:0] rdy_state;

  packet_cutter_top i_dut (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Low n byte lanes set
  function automatic logic [BYTES-1:0] strb_lanes(input int n);
    logic [BYTES-1:0] m;
    m = '0;
    for (int i = 0; i < BYTES; i++) begin
      m[i] = (i < n);
    end
    return m;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s at %0t", msg, $time);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] expected);
    assert (got === expected) else begin
      $display("Error at %0t: %s got %0h expected %0h", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, errors - err_start);
  endtask

  task automatic reg_wr(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    @(posedge axi_aclk);
    reg_write <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge axi_aclk);
    reg_write <= 1'b0;
  endtask

  // Read strobe followed by rvalid for exactly one cycle
  task automatic reg_check(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] expected);
    @(posedge axi_aclk);
    reg_read <= 1'b1;
    reg_addr <= addr;
    @(negedge axi_aclk);
    check_value("reg_rvalid", reg_rvalid, 1'b0);
    @(posedge axi_aclk);
    reg_read <= 1'b0;
    @(negedge axi_aclk);
    check_value("reg_rvalid", reg_rvalid, 1'b1);
    check_value("reg_rdata", reg_rdata, expected);
    @(negedge axi_aclk);
    check_value("reg_rvalid", reg_rvalid, 1'b0);
  endtask

  task automatic send_packet(input int len, input int exp_len, input int exp_beats);
    int                     in_beats;
    int                     wait_cnt;
    logic [DATA_WIDTH-1:0]  data;
    logic [TUSER_WIDTH-1:0] user;
    logic [TUSER_WIDTH-1:0] user_out;
    in_beats = (len + BYTES - 1) / BYTES;
    for (int b = 0; b < in_beats; b++) begin
      for (int w = 0; w < DATA_WIDTH / 32; w++) begin
        data_state = lcg_next(data_state);
        data[w*32 +: 32] = data_state;
      end
      for (int w = 0; w < TUSER_WIDTH / 32; w++) begin
        data_state = lcg_next(data_state);
        user[w*32 +: 32] = data_state;
      end
      user_out = user;
      if (b == 0) begin
        user[LEN_WIDTH-1:0]     = len[LEN_WIDTH-1:0];
        user_out[LEN_WIDTH-1:0] = exp_len[LEN_WIDTH-1:0];
      end
      if (b < exp_beats) begin
        exp_data.push_back(data);
        exp_user.push_back(user_out);
        exp_last.push_back(b == exp_beats - 1);
        exp_strb.push_back((b == exp_beats - 1) ? strb_lanes(exp_len - b * BYTES) : '1);
      end
      @(posedge axi_aclk);
      s_tvalid <= 1'b1;
      s_tdata  <= data;
      s_tuser  <= user;
      s_tstrb  <= strb_lanes(len - b * BYTES);
      s_tlast  <= (b == in_beats - 1);
      wait_cnt = 0;
      @(negedge axi_aclk);
      while (!s_tready) begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT) abort_run("Timeout waiting for s_tready");
        @(negedge axi_aclk);
      end
    end
    @(posedge axi_aclk);
    s_tvalid <= 1'b0;
  endtask

  initial begin
    axi_aclk = 1'b0;
    forever #5 axi_aclk = ~axi_aclk;
  end

  // Output ready with random gaps when enabled
  initial begin
    m_tready  = 1'b1;
    rdy_state = 32'hc9bc_3674;
    forever begin
      @(posedge axi_aclk);
      rdy_state = lcg_next(rdy_state);
      m_tready <= gaps_on ? (rdy_state[17:16] != 2'b00) : 1'b1;
    end
  end

  // Output monitor sampling at the falling edge
  initial begin
    forever begin
      @(negedge axi_aclk);
      if (!reset && !m_tvalid) begin
        // Empty slice always takes a beat
        check_value("s_tready", s_tready, 1'b1);
      end
      if (!reset && m_tvalid && !m_tready) begin
        // Full slice that cannot drain stalls the input
        check_value("s_tready", s_tready, 1'b0);
      end
      if (!reset && m_tvalid && m_tready) begin
        rx_beats++;
        assert (exp_data.size() > 0) else begin
          $display("Output beat at %0t with no kept input beat left", $time);
          errors++;
        end
        if (exp_data.size() > 0) begin
          check_value("m_tdata", m_tdata, exp_data.pop_front());
          check_value("m_tstrb", m_tstrb, exp_strb.pop_front());
          check_value("m_tuser", m_tuser, exp_user.pop_front());
          check_value("m_tlast", m_tlast, exp_last.pop_front());
        end
      end
    end
  end

  initial begin : main_flow
    int          idx;
    int          wait_cnt;
    int          err_start;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    reset      = 1'b1;
    reg_write  = 1'b0;
    reg_read   = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    s_tdata    = '0;
    s_tstrb    = '0;
    s_tuser    = '0;
    s_tvalid   = 1'b0;
    s_tlast    = 1'b0;
    gaps_on    = 1'b0;
    errors     = 0;
    tests      = 0;
    rx_beats   = 0;
    data_state = 32'hc9bc_3674;
    for (idx = 0; idx < PAT_DEPTH; idx++) begin
      pat_mem[idx] = '0;
    end
    $readmemh("testbench/cutter_patterns.hex", pat_mem);
    if (pat_mem[0] == 32'd0) abort_run("Pattern file missing or empty");
    repeat (16) @(posedge axi_aclk);
    reset <= 1'b0;

    err_start = errors;
    @(negedge axi_aclk);
    check_value("m_tvalid", m_tvalid, 1'b0);
    check_value("reg_rvalid", reg_rvalid, 1'b0);
    reg_check(ADDR_CTRL, 32'd0);
    reg_check(ADDR_CUT_WORDS, 32'd0);
    reg_check(ADDR_CUT_BYTES, 32'd0);
    report_test("reset state", err_start);

    err_start = errors;
    reg_wr(4'd7, 32'hdead_beef);
    reg_check(4'd7, 32'd0);
    reg_check(4'hf, 32'd0);
    report_test("unmapped address", err_start);

    // Records of four words with the type first
    idx = 0;
    while (idx + 3 < PAT_DEPTH && pat_mem[idx] != 32'd0) begin
      a = pat_mem[idx+1];
      b = pat_mem[idx+2];
      c = pat_mem[idx+3];
      err_start = errors;
      case (pat_mem[idx])
        32'd1: begin
          reg_wr(ADDR_CTRL, a);
          reg_wr(ADDR_CUT_WORDS, b);
          reg_wr(ADDR_CUT_BYTES, c);
          reg_check(ADDR_CTRL, {31'd0, a[0]});
          reg_check(ADDR_CUT_WORDS, b);
          reg_check(ADDR_CUT_BYTES, c);
          report_test($sformatf("config en=%0d words=%0d bytes=%0d", a, b, c), err_start);
        end
        32'd2: begin
          rx_beats = 0;
          send_packet(a, b, c);
          // Drained once no beat is expected and the slice is empty
          wait_cnt = 0;
          @(negedge axi_aclk);
          while (exp_data.size() > 0 || m_tvalid) begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT) abort_run("Timeout waiting for output beats");
            @(negedge axi_aclk);
          end
          check_value("output beat count", rx_beats, c);
          report_test($sformatf("packet len=%0d out=%0d beats=%0d", a, b, c), err_start);
        end
        32'd3: begin
          gaps_on = a[0];
          report_test($sformatf("ready gaps %0d", a[0]), err_start);
        end
        default: begin
          abort_run("Unknown record type in pattern file");
        end
      endcase
      idx += 4;
    end

    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: rtl/packet_cutter_top.sv
//##########################################################
// Packet cutter top level
// Register file, cut decision and output slice
//##########################################################

`timescale 1ns/1ps

module packet_cutter_top #(
  parameter int DATA_WIDTH  = 64,
  parameter int TUSER_WIDTH = 128
) (
  input  logic                                  axi_aclk,
  input  logic                                  reset,

  // Register port
  input  logic                                  reg_write,
  input  logic                                  reg_read,
  input  logic [cutter_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
  input  logic [cutter_pkg::REG_WIDTH-1:0]      reg_wdata,
  output logic [cutter_pkg::REG_WIDTH-1:0]      reg_rdata,
  output logic                                  reg_rvalid,

  // Input stream
  input  logic [DATA_WIDTH-1:0]                 s_tdata,
  input  logic [DATA_WIDTH/8-1:0]               s_tstrb,
  input  logic [TUSER_WIDTH-1:0]                s_tuser,
  input  logic                                  s_tvalid,
  output logic                                  s_tready,
  input  logic                                  s_tlast,

  // Output stream
  output logic [DATA_WIDTH-1:0]                 m_tdata,
  output logic [DATA_WIDTH/8-1:0]               m_tstrb,
  output logic [TUSER_WIDTH-1:0]                m_tuser,
  output logic                                  m_tvalid,
  input  logic                                  m_tready,
  output logic                                  m_tlast
);
  import cutter_pkg::*;

  logic                    cut_en;
  logic [REG_WIDTH-1:0]    cut_words;
  logic [REG_WIDTH-1:0]    cut_bytes;

  logic                    beat_keep;
  logic                    beat_last;
  logic [DATA_WIDTH/8-1:0] beat_strb;
  logic [TUSER_WIDTH-1:0]  beat_tuser;

  cutter_regs i_regs (
    .axi_aclk   (axi_aclk),
    .reset      (reset),
    .reg_write  (reg_write),
    .reg_read   (reg_read),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .cut_en     (cut_en),
    .cut_words  (cut_words),
    .cut_bytes  (cut_bytes)
  );

  // Decision is combinational on the beat at the input
  cut_control #(
    .DATA_WIDTH  (DATA_WIDTH),
    .TUSER_WIDTH (TUSER_WIDTH)
  ) i_control (
    .axi_aclk   (axi_aclk),
    .reset      (reset),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tlast    (s_tlast),
    .s_tuser    (s_tuser),
    .s_tstrb    (s_tstrb),
    .cut_en     (cut_en),
    .cut_words  (cut_words),
    .cut_bytes  (cut_bytes),
    .beat_keep  (beat_keep),
    .beat_last  (beat_last),
    .beat_strb  (beat_strb),
    .beat_tuser (beat_tuser)
  );

  cut_output_stage #(
    .DATA_WIDTH  (DATA_WIDTH),
    .TUSER_WIDTH (TUSER_WIDTH)
  ) i_output (
    .axi_aclk   (axi_aclk),
    .reset      (reset),
    .s_tdata    (s_tdata),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .beat_keep  (beat_keep),
    .beat_last  (beat_last),
    .beat_strb  (beat_strb),
    .beat_tuser (beat_tuser),
    .m_tdata    (m_tdata),
    .m_tstrb    (m_tstrb),
    .m_tuser    (m_tuser),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tlast    (m_tlast)
  );

endmodule

// File: rtl/cut_output_stage.sv
//##########################################################
// Packet cutter output slice
// Single register stage, drops beats not marked as kept
//##########################################################

`timescale 1ns/1ps

module cut_output_stage #(
  parameter int DATA_WIDTH  = 64,
  parameter int TUSER_WIDTH = 128
) (
  input  logic                    axi_aclk,
  input  logic                    reset,

  // Input beat and its cut decision
  input  logic [DATA_WIDTH-1:0]   s_tdata,
  input  logic                    s_tvalid,
  output logic                    s_tready,
  input  logic                    beat_keep,
  input  logic                    beat_last,
  input  logic [DATA_WIDTH/8-1:0] beat_strb,
  input  logic [TUSER_WIDTH-1:0]  beat_tuser,

  // Output stream
  output logic [DATA_WIDTH-1:0]   m_tdata,
  output logic [DATA_WIDTH/8-1:0] m_tstrb,
  output logic [TUSER_WIDTH-1:0]  m_tuser,
  output logic                    m_tvalid,
  input  logic                    m_tready,
  output logic                    m_tlast
);

  logic load;

  // Room when empty or when the held beat leaves this cycle
  assign s_tready = !m_tvalid || m_tready;

  assign load = s_tvalid && s_tready && beat_keep;

  // Dropped beats are accepted and leave the slice empty
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      m_tvalid <= 1'b0;
    end else if (s_tready) begin
      m_tvalid <= s_tvalid && beat_keep;
    end
  end

  // Payload
  always_ff @(posedge axi_aclk) begin
    if (load) begin
      m_tdata <= s_tdata;
      m_tstrb <= beat_strb;
      m_tuser <= beat_tuser;
      m_tlast <= beat_last;
    end
  end

endmodule

// File: rtl/cut_control.sv
//##########################################################
// Packet cut decision
// Counts beats and marks kept beats, new last and length
//##########################################################

`timescale 1ns/1ps

module cut_control #(
  parameter int DATA_WIDTH  = 64,
  parameter int TUSER_WIDTH = 128
) (
  input  logic                             axi_aclk,
  input  logic                             reset,
  input  logic                             s_tvalid,
  input  logic                             s_tready,
  input  logic                             s_tlast,
  input  logic [TUSER_WIDTH-1:0]           s_tuser,
  input  logic [DATA_WIDTH/8-1:0]          s_tstrb,
  input  logic                             cut_en,
  input  logic [cutter_pkg::REG_WIDTH-1:0] cut_words,
  input  logic [cutter_pkg::REG_WIDTH-1:0] cut_bytes,
  output logic                             beat_keep,
  output logic                             beat_last,
  output logic [DATA_WIDTH/8-1:0]          beat_strb,
  output logic [TUSER_WIDTH-1:0]           beat_tuser
);
  import cutter_pkg::*;

  localparam int BYTES       = DATA_WIDTH / 8;
  localparam int BCNT_WIDTH  = $clog2(BYTES + 1);
  localparam int LIMIT_WIDTH = REG_WIDTH + BCNT_WIDTH;

  logic                   accept;
  logic                   in_pkt;
  logic                   first_beat;
  logic [REG_WIDTH-1:0]   beat_cnt;

  // Decision and config captured on the first beat
  logic                   cut_hold;
  logic [REG_WIDTH-1:0]   words_hold;
  logic [BCNT_WIDTH-1:0]  bytes_hold;

  logic [BCNT_WIDTH-1:0]  eff_bytes;
  logic [LIMIT_WIDTH-1:0] limit;
  logic [LEN_WIDTH-1:0]   pkt_len;
  logic                   cut_first;
  logic                   cut_active;
  logic [REG_WIDTH-1:0]   words_now;
  logic [BCNT_WIDTH-1:0]  bytes_now;
  logic                   cut_last;
  logic [BYTES-1:0]       keep_mask;

  assign accept     = s_tvalid && s_tready;
  assign first_beat = !in_pkt;

  // Zero or oversized byte count means a full last beat
  assign eff_bytes = (cut_bytes == '0 || cut_bytes > REG_WIDTH'(BYTES)) ?
                     BCNT_WIDTH'(BYTES) : cut_bytes[BCNT_WIDTH-1:0];

  assign limit = (LIMIT_WIDTH'(cut_words) - LIMIT_WIDTH'(1)) * LIMIT_WIDTH'(BYTES)
               + LIMIT_WIDTH'(eff_bytes);

  assign pkt_len   = s_tuser[LEN_WIDTH-1:0];
  assign cut_first = cut_en && (cut_words != '0) && (LIMIT_WIDTH'(pkt_len) > limit);

  // Live config on the first beat, held values for the rest
  assign cut_active = first_beat ? cut_first : cut_hold;
  assign words_now  = first_beat ? cut_words : words_hold;
  assign bytes_now  = first_beat ? eff_bytes : bytes_hold;

  assign cut_last  = cut_active && (beat_cnt == words_now - REG_WIDTH'(1));
  assign beat_keep = !cut_active || (beat_cnt < words_now);
  assign beat_last = cut_last || s_tlast;

  // Low lanes only, shift by BYTES gives a full mask
  assign keep_mask = ~({BYTES{1'b1}} << bytes_now);
  assign beat_strb = cut_last ? keep_mask : s_tstrb;

  always_comb begin
    beat_tuser = s_tuser;
    // Limit fits the length field since it is below the old length
    if (first_beat && cut_first) begin
      beat_tuser[LEN_WIDTH-1:0] = limit[LEN_WIDTH-1:0];
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      in_pkt     <= 1'b0;
      beat_cnt   <= '0;
      cut_hold   <= 1'b0;
      words_hold <= '0;
      bytes_hold <= '0;
    end else if (accept) begin
      in_pkt   <= !s_tlast;
      beat_cnt <= s_tlast ? '0 : beat_cnt + REG_WIDTH'(1);
      if (first_beat) begin
        cut_hold   <= cut_first;
        words_hold <= cut_words;
        bytes_hold <= eff_bytes;
      end
    end
  end

endmodule

// File: rtl/cutter_regs.sv
//##########################################################
// Packet cutter register file
// Strobe write/read port holding the cut configuration
//##########################################################

`timescale 1ns/1ps

module cutter_regs (
  input  logic                                  axi_aclk,
  input  logic                                  reset,
  input  logic                                  reg_write,
  input  logic                                  reg_read,
  input  logic [cutter_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
  input  logic [cutter_pkg::REG_WIDTH-1:0]      reg_wdata,
  output logic [cutter_pkg::REG_WIDTH-1:0]      reg_rdata,
  output logic                                  reg_rvalid,
  output logic                                  cut_en,
  output logic [cutter_pkg::REG_WIDTH-1:0]      cut_words,
  output logic [cutter_pkg::REG_WIDTH-1:0]      cut_bytes
);
  import cutter_pkg::*;

  logic [REG_WIDTH-1:0] read_mux;

  // Write decode, unmapped addresses are ignored
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      cut_en    <= 1'b0;
      cut_words <= '0;
      cut_bytes <= '0;
    end else if (reg_write) begin
      case (reg_addr)
        ADDR_CTRL: begin
          cut_en <= reg_wdata[0];
        end
        ADDR_CUT_WORDS: begin
          cut_words <= reg_wdata;
        end
        ADDR_CUT_BYTES: begin
          cut_bytes <= reg_wdata;
        end
        default: begin
        end
      endcase
    end
  end

  // Read select
  always_comb begin
    case (reg_addr)
      ADDR_CTRL:      read_mux = {{(REG_WIDTH-1){1'b0}}, cut_en};
      ADDR_CUT_WORDS: read_mux = cut_words;
      ADDR_CUT_BYTES: read_mux = cut_bytes;
      default:        read_mux = '0;
    endcase
  end

  // Read data returns one cycle after the strobe
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      reg_rvalid <= 1'b0;
      reg_rdata  <= '0;
    end else begin
      reg_rvalid <= reg_read;
      if (reg_read) begin
        reg_rdata <= read_mux;
      end
    end
  end

endmodule

// File: rtl/cutter_pkg.sv
//##########################################################
// Packet cutter shared definitions
// Register map, register widths and sideband length field
//##########################################################

package cutter_pkg;

  // Register port geometry
  localparam int REG_WIDTH      = 32;
  localparam int REG_ADDR_WIDTH = 4;

  // Register word indices
  // CTRL bit 0 is the cut enable, the other bits read as zero
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CTRL      = 4'd0;
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CUT_WORDS = 4'd1;
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CUT_BYTES = 4'd2;

  // Packet length in bytes, carried in the low bits of tuser
  // on the first beat of each packet
  localparam int LEN_WIDTH = 16;

endpackage
